// File: design/aluExecute.sv
`timescale 1ns/1ps

module aluExecute (
	input  logic              clk,
	input  logic              reset,
	decodeExecuteIf.execute   fromDec,
	executeResultIf.execute   toRes
);

	cpuPkg::aluCtrl_t  aluCtrl;
	cpuPkg::word_t     aluB;
	cpuPkg::word_t     aluResult;

	////////////////////////////////////////////////////////////
	// ALU control
	////////////////////////////////////////////////////////////
	always_comb begin
		// lw, sw and addi all add
		aluCtrl = cpuPkg::ALU_ADD;
		if (fromDec.aluOpClass) begin
			case (fromDec.funct)
				cpuPkg::FUNCT_ADD: aluCtrl = cpuPkg::ALU_ADD;
				cpuPkg::FUNCT_SUB: aluCtrl = cpuPkg::ALU_SUB;
				cpuPkg::FUNCT_AND: aluCtrl = cpuPkg::ALU_AND;
				cpuPkg::FUNCT_OR:  aluCtrl = cpuPkg::ALU_OR;
				cpuPkg::FUNCT_SLT: aluCtrl = cpuPkg::ALU_SLT;
				// no matching op, ALU falls back to pass A
				default:           aluCtrl = '1;
			endcase
		end
	end

	// operand B mux, register or immediate
	assign aluB = fromDec.aluSrc ? fromDec.imm : fromDec.operandB;

	always_comb begin
		case (aluCtrl)
			cpuPkg::ALU_AND: aluResult = fromDec.operandA & aluB;
			cpuPkg::ALU_OR:  aluResult = fromDec.operandA | aluB;
			cpuPkg::ALU_ADD: aluResult = fromDec.operandA + aluB;
			cpuPkg::ALU_SUB: aluResult = fromDec.operandA - aluB;
			// signed compare
			cpuPkg::ALU_SLT: aluResult = ($signed(fromDec.operandA) < $signed(aluB)) ?
				cpuPkg::word_t'(1) : '0;
			default:         aluResult = fromDec.operandA;
		endcase
	end

	////////////////////////////////////////////////////////////
	// execute/memory stage register
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			toRes.valid    <= 1'b0;
			toRes.regWrite <= 1'b0;
			toRes.memRead  <= 1'b0;
			toRes.memWrite <= 1'b0;
		end else begin
			toRes.valid    <= fromDec.valid;
			toRes.regWrite <= fromDec.regWrite;
			toRes.memRead  <= fromDec.memRead;
			toRes.memWrite <= fromDec.memWrite;
		end
	end

	always_ff @(posedge clk) begin
		toRes.aluResult <= aluResult;
		// rt value, used only by sw
		toRes.storeData <= fromDec.operandB;
		toRes.dest      <= fromDec.dest;
	end

endmodule

// File: design/cpuPkg.sv
package cpuPkg;

	////////////////////////////////////////////////////////////
	// instruction field and datapath widths
	////////////////////////////////////////////////////////////
	localparam int WORD_W     = 32;
	localparam int REG_W      = 5;
	localparam int OPCODE_W   = 6;
	localparam int FUNCT_W    = 6;
	localparam int IMM_W      = 16;
	localparam int ALU_CTRL_W = 4;
	localparam int MEM_ADDR_W = 6;

	// storage sizes
	localparam int REG_COUNT  = 32;
	localparam int DMEM_WORDS = 64;

	typedef logic [WORD_W-1:0]     word_t;
	typedef logic [REG_W-1:0]      regAddr_t;
	typedef logic [OPCODE_W-1:0]   opcode_t;
	typedef logic [FUNCT_W-1:0]    funct_t;
	typedef logic [ALU_CTRL_W-1:0] aluCtrl_t;
	typedef logic [MEM_ADDR_W-1:0] memAddr_t;

	////////////////////////////////////////////////////////////
	// primary opcodes
	////////////////////////////////////////////////////////////
	localparam opcode_t OPC_RTYPE = 6'd0;
	localparam opcode_t OPC_ADDI  = 6'd8;
	localparam opcode_t OPC_LW    = 6'd35;
	localparam opcode_t OPC_SW    = 6'd43;
	// branch and jump retire as no-ops
	localparam opcode_t OPC_BEQ   = 6'd4;
	localparam opcode_t OPC_J     = 6'd2;

	// R-format function field
	localparam funct_t FUNCT_ADD = 6'd32;
	localparam funct_t FUNCT_SUB = 6'd34;
	localparam funct_t FUNCT_AND = 6'd36;
	localparam funct_t FUNCT_OR  = 6'd37;
	localparam funct_t FUNCT_SLT = 6'd42;

	// ALU operation codes, classic MIPS encoding
	localparam aluCtrl_t ALU_AND = 4'b0000;
	localparam aluCtrl_t ALU_OR  = 4'b0001;
	localparam aluCtrl_t ALU_ADD = 4'b0010;
	localparam aluCtrl_t ALU_SUB = 4'b0110;
	localparam aluCtrl_t ALU_SLT = 4'b0111;

	// instruction port four-phase handshake
	typedef enum logic {
		HS_IDLE,
		HS_ACK
	} hsState_t;

endpackage

// File: design/decodeExecuteIf.sv
`timescale 1ns/1ps

interface decodeExecuteIf;

	// stage valid and operands
	logic              valid;
	cpuPkg::word_t     operandA;
	cpuPkg::word_t     operandB;
	// sign-extended immediate
	cpuPkg::word_t     imm;
	cpuPkg::funct_t    funct;
	cpuPkg::regAddr_t  dest;

	// controls carried down the pipe
	logic              regWrite;
	logic              memRead;
	logic              memWrite;
	logic              aluSrc;
	// high: R-format, ALU op from funct
	logic              aluOpClass;

	modport decode (output valid, operandA, operandB, imm, funct, dest,
		regWrite, memRead, memWrite, aluSrc, aluOpClass);
	modport execute (input valid, operandA, operandB, imm, funct, dest,
		regWrite, memRead, memWrite, aluSrc, aluOpClass);

endinterface

// File: design/executeResultIf.sv
`timescale 1ns/1ps

interface executeResultIf;

	logic              valid;
	// ALU output doubles as memory address
	cpuPkg::word_t     aluResult;
	// rt value for sw
	cpuPkg::word_t     storeData;
	cpuPkg::regAddr_t  dest;

	logic              regWrite;
	logic              memRead;
	logic              memWrite;

	modport execute (output valid, aluResult, storeData, dest,
		regWrite, memRead, memWrite);
	modport result (input valid, aluResult, storeData, dest,
		regWrite, memRead, memWrite);

endinterface

// File: design/instrDecode.sv
`timescale 1ns/1ps

module instrDecode (
	input  logic              clk,
	input  logic              reset,
	input  logic              instrReq,
	input  cpuPkg::word_t     instr,
	output logic              instrAck,
	input  logic              wbValid,
	input  cpuPkg::regAddr_t  wbReg,
	input  cpuPkg::word_t     wbData,
	decodeExecuteIf.decode    toExec
);

	// handshake and capture slot
	cpuPkg::hsState_t  hsState;
	logic              slotValid;
	cpuPkg::word_t     slotInstr;
	logic              capture;
	logic              issue;
	logic              hazard;

	// fields of the held instruction
	cpuPkg::opcode_t   opcode;
	cpuPkg::regAddr_t  rs;
	cpuPkg::regAddr_t  rt;
	cpuPkg::regAddr_t  rd;

	// decoded controls
	logic              regWrite;
	logic              memRead;
	logic              memWrite;
	logic              aluSrc;
	logic              aluOpClass;
	logic              regDst;
	logic              usesRs;
	logic              usesRt;

	cpuPkg::word_t     regs [cpuPkg::REG_COUNT];

	// execute/memory entry, tracked here one edge behind decode/execute
	logic              exMemWrite;
	cpuPkg::regAddr_t  exMemDest;

	// register read with writeback bypass, $0 hardwired
	function automatic cpuPkg::word_t readReg(cpuPkg::regAddr_t addr);
		if (addr == '0)
			return '0;
		else if (wbValid && wbReg == addr)
			return wbData;
		return regs[addr];
	endfunction

	// src still waiting on an older in-flight write
	function automatic logic pending(cpuPkg::regAddr_t src);
		return (src != '0) &&
			((toExec.valid && toExec.regWrite && toExec.dest == src) ||
			(exMemWrite && exMemDest == src));
	endfunction

	////////////////////////////////////////////////////////////
	// instruction port handshake
	////////////////////////////////////////////////////////////
	// take a new word only if the slot frees up on this edge
	assign capture  = (hsState == cpuPkg::HS_IDLE) && instrReq && (!slotValid || issue);
	assign instrAck = (hsState == cpuPkg::HS_ACK);

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			hsState   <= cpuPkg::HS_IDLE;
			slotValid <= 1'b0;
		end else begin
			case (hsState)
				cpuPkg::HS_IDLE: begin
					if (capture)
						hsState <= cpuPkg::HS_ACK;
				end
				cpuPkg::HS_ACK: begin
					// hold ack until req goes away
					if (!instrReq)
						hsState <= cpuPkg::HS_IDLE;
				end
				default: hsState <= cpuPkg::HS_IDLE;
			endcase
			slotValid <= capture || (slotValid && !issue);
		end
	end

	always_ff @(posedge clk) begin
		if (capture)
			slotInstr <= instr;
	end

	////////////////////////////////////////////////////////////
	// control decode
	////////////////////////////////////////////////////////////
	assign opcode = slotInstr[31:26];
	assign rs     = slotInstr[25:21];
	assign rt     = slotInstr[20:16];
	assign rd     = slotInstr[15:11];

	always_comb begin
		regWrite   = 1'b0;
		memRead    = 1'b0;
		memWrite   = 1'b0;
		aluSrc     = 1'b0;
		aluOpClass = 1'b0;
		regDst     = 1'b0;
		usesRs     = 1'b0;
		usesRt     = 1'b0;
		case (opcode)
			cpuPkg::OPC_RTYPE: begin
				regWrite   = 1'b1;
				aluOpClass = 1'b1;
				regDst     = 1'b1;
				usesRs     = 1'b1;
				usesRt     = 1'b1;
			end
			cpuPkg::OPC_ADDI: begin
				regWrite = 1'b1;
				aluSrc   = 1'b1;
				usesRs   = 1'b1;
			end
			cpuPkg::OPC_LW: begin
				regWrite = 1'b1;
				memRead  = 1'b1;
				aluSrc   = 1'b1;
				usesRs   = 1'b1;
			end
			cpuPkg::OPC_SW: begin
				memWrite = 1'b1;
				aluSrc   = 1'b1;
				usesRs   = 1'b1;
				usesRt   = 1'b1;
			end
			// branch and jump flow through with no side effects
			cpuPkg::OPC_BEQ, cpuPkg::OPC_J: begin
				regWrite = 1'b0;
			end
			default: begin
				regWrite = 1'b0;
			end
		endcase
	end

	// no forwarding, so wait out any producer still ahead of writeback
	assign hazard = (usesRs && pending(rs)) || (usesRt && pending(rt));
	assign issue  = slotValid && !hazard;

	////////////////////////////////////////////////////////////
	// register file
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			for (int i = 0; i < cpuPkg::REG_COUNT; i++)
				regs[i] <= '0;
		end else if (wbValid && wbReg != '0) begin
			regs[wbReg] <= wbData;
		end
	end

	////////////////////////////////////////////////////////////
	// decode/execute stage register
	////////////////////////////////////////////////////////////
	// bubble when nothing issues
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			toExec.valid    <= 1'b0;
			toExec.regWrite <= 1'b0;
			toExec.memRead  <= 1'b0;
			toExec.memWrite <= 1'b0;
			exMemWrite      <= 1'b0;
		end else begin
			toExec.valid    <= issue;
			toExec.regWrite <= issue && regWrite;
			toExec.memRead  <= issue && memRead;
			toExec.memWrite <= issue && memWrite;
			exMemWrite      <= toExec.valid && toExec.regWrite;
		end
	end

	always_ff @(posedge clk) begin
		toExec.operandA   <= readReg(rs);
		toExec.operandB   <= readReg(rt);
		toExec.imm        <= {{(cpuPkg::WORD_W - cpuPkg::IMM_W){slotInstr[15]}},
			slotInstr[cpuPkg::IMM_W-1:0]};
		toExec.funct      <= slotInstr[5:0];
		toExec.dest       <= regDst ? rd : rt;
		toExec.aluSrc     <= aluSrc;
		toExec.aluOpClass <= aluOpClass;
		exMemDest         <= toExec.dest;
	end

endmodule

// File: design/memResult.sv
`timescale 1ns/1ps

module memResult (
	input  logic              clk,
	input  logic              reset,
	executeResultIf.result    fromExec,
	output logic              wbValid,
	output cpuPkg::regAddr_t  wbReg,
	output cpuPkg::word_t     wbData
);

	cpuPkg::word_t     dmem [cpuPkg::DMEM_WORDS];
	cpuPkg::memAddr_t  memIndex;
	cpuPkg::word_t     loadData;

	// writeback stage payload
	logic              wbLoad;
	cpuPkg::word_t     wbLoadData;
	cpuPkg::word_t     wbAluData;

	////////////////////////////////////////////////////////////
	// data memory
	////////////////////////////////////////////////////////////
	// word index from byte address
	assign memIndex = fromExec.aluResult[7:2];
	// combinational read for lw
	assign loadData = dmem[memIndex];

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			for (int i = 0; i < cpuPkg::DMEM_WORDS; i++)
				dmem[i] <= '0;
		end else if (fromExec.valid && fromExec.memWrite) begin
			dmem[memIndex] <= fromExec.storeData;
		end
	end

	////////////////////////////////////////////////////////////
	// memory/writeback stage register
	////////////////////////////////////////////////////////////
	// dest 0 writes never reach the port
	always_ff @(posedge clk or posedge reset) begin
		if (reset)
			wbValid <= 1'b0;
		else
			wbValid <= fromExec.valid && fromExec.regWrite && fromExec.dest != '0;
	end

	always_ff @(posedge clk) begin
		wbReg      <= fromExec.dest;
		wbLoad     <= fromExec.memRead;
		wbLoadData <= loadData;
		wbAluData  <= fromExec.aluResult;
	end

	// load data for lw, ALU result otherwise
	assign wbData = wbLoad ? wbLoadData : wbAluData;

endmodule

// File: design/pipelineTop.sv
`timescale 1ns/1ps

module pipelineTop (
	input  logic              clk,
	input  logic              reset,
	input  logic              instrReq,
	input  cpuPkg::word_t     instr,
	output logic              instrAck,
	output logic              wbValid,
	output cpuPkg::regAddr_t  wbReg,
	output cpuPkg::word_t     wbData
);

	// stage-to-stage bundles
	decodeExecuteIf decExec ();
	executeResultIf exRes ();

	////////////////////////////////////////////////////////////
	// decode, execute, memory/writeback
	////////////////////////////////////////////////////////////
	instrDecode uDecode (
		.clk      (clk),
		.reset    (reset),
		.instrReq (instrReq),
		.instr    (instr),
		.instrAck (instrAck),
		.wbValid  (wbValid),
		.wbReg    (wbReg),
		.wbData   (wbData),
		.toExec   (decExec.decode)
	);

	aluExecute uExecute (
		.clk     (clk),
		.reset   (reset),
		.fromDec (decExec.execute),
		.toRes   (exRes.execute)
	);

	// writeback goes out and back into the register file
	memResult uResult (
		.clk      (clk),
		.reset    (reset),
		.fromExec (exRes.result),
		.wbValid  (wbValid),
		.wbReg    (wbReg),
		.wbData   (wbData)
	);

endmodule

// File: flist.f
design/cpuPkg.sv
design/decodeExecuteIf.sv
design/executeResultIf.sv
design/instrDecode.sv
design/aluExecute.sv
design/memResult.sv
design/pipelineTop.sv
verification/pipelineTb.sv

// File: run.sh
#!/bin/sh
# build and run the pipeline testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module pipelineTb -f flist.f -o simv || exit 1

simOut="$(./obj_dir/simv)"
echo "$simOut"

echo "$simOut" | grep -qx "STATUS: PASS" && echo "simulation passed" || { echo "simulation failed"; exit 1; }

// File: verification/pipelineTb.sv
`timescale 1ns/1ps

module pipelineTb;

	// clock, stimulus and run-length constants
	localparam int          CLK_HALF         = 10;
	localparam int          DRIVE_DELAY      = 1;
	localparam int          RESET_CYCLES     = 2;
	localparam int unsigned RAND_SEED        = 32'h8e0a;
	localparam int          CYCLES_PER_INSTR = 40;
	localparam int          BASE_CYCLES      = 100;
	localparam int          RANDOM_COUNT     = 60;

	logic              clk = 1'b0;
	logic              reset;
	logic              instrReq;
	cpuPkg::word_t     instr;
	logic              instrAck;
	logic              wbValid;
	cpuPkg::regAddr_t  wbReg;
	cpuPkg::word_t     wbData;

	// reference model state
	cpuPkg::word_t     refRegs [cpuPkg::REG_COUNT];
	cpuPkg::word_t     refMem [cpuPkg::DMEM_WORDS];
	cpuPkg::regAddr_t  expReg [$];
	cpuPkg::word_t     expData [$];
	string             expTest [$];

	string             testName = "reset";
	int                valueErrors = 0;
	int                otherErrors = 0;
	int                sentCount = 0;
	int                cycleCount = 0;
	int unsigned       seedValue;

	pipelineTop dut (
		.clk      (clk),
		.reset    (reset),
		.instrReq (instrReq),
		.instr    (instr),
		.instrAck (instrAck),
		.wbValid  (wbValid),
		.wbReg    (wbReg),
		.wbData   (wbData)
	);

	always #CLK_HALF clk = ~clk;

	////////////////////////////////////////////////////////////
	// compare tasks
	////////////////////////////////////////////////////////////
	task automatic checkBit(string name, string what, logic exp, logic act);
		if (exp !== act) begin
			valueErrors++;
			$display("[ERROR] %s: %s expected %b, got %b", name, what, exp, act);
		end
	endtask

	task automatic checkReg(string name, cpuPkg::regAddr_t exp, cpuPkg::regAddr_t act);
		if (exp !== act) begin
			valueErrors++;
			$display("[ERROR] %s: wbReg expected %0d, got %0d", name, exp, act);
		end
	endtask

	task automatic checkWord(string name, cpuPkg::word_t exp, cpuPkg::word_t act);
		if (exp !== act) begin
			valueErrors++;
			$display("[ERROR] %s: wbData expected %h, got %h", name, exp, act);
		end
	endtask

	////////////////////////////////////////////////////////////
	// instruction encoding and reference model
	////////////////////////////////////////////////////////////
	function automatic cpuPkg::word_t rType(cpuPkg::regAddr_t rs, cpuPkg::regAddr_t rt,
		cpuPkg::regAddr_t rd, cpuPkg::funct_t funct);
		return {cpuPkg::OPC_RTYPE, rs, rt, rd, 5'd0, funct};
	endfunction

	function automatic cpuPkg::word_t iType(cpuPkg::opcode_t op, cpuPkg::regAddr_t rs,
		cpuPkg::regAddr_t rt, logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	// ISA semantics, queues the expected write-back in program order
	function automatic void applyToModel(cpuPkg::word_t ins);
		cpuPkg::word_t     a;
		cpuPkg::word_t     b;
		cpuPkg::word_t     imm;
		cpuPkg::word_t     addr;
		cpuPkg::word_t     result;
		cpuPkg::regAddr_t  dest;
		logic              writes;
		a      = refRegs[ins[25:21]];
		b      = refRegs[ins[20:16]];
		imm    = {{16{ins[15]}}, ins[15:0]};
		addr   = a + imm;
		dest   = ins[20:16];
		result = '0;
		writes = 1'b0;
		case (ins[31:26])
			cpuPkg::OPC_RTYPE: begin
				writes = 1'b1;
				dest   = ins[15:11];
				case (ins[5:0])
					cpuPkg::FUNCT_ADD: result = a + b;
					cpuPkg::FUNCT_SUB: result = a - b;
					cpuPkg::FUNCT_AND: result = a & b;
					cpuPkg::FUNCT_OR:  result = a | b;
					cpuPkg::FUNCT_SLT: result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
					default:           result = a;
				endcase
			end
			cpuPkg::OPC_ADDI: begin
				writes = 1'b1;
				result = a + imm;
			end
			cpuPkg::OPC_LW: begin
				writes = 1'b1;
				result = refMem[addr[7:2]];
			end
			// store data is rt
			cpuPkg::OPC_SW: refMem[addr[7:2]] = b;
			default: writes = 1'b0;
		endcase
		// $0 writes never show up on the port
		if (writes && dest != 5'd0) begin
			refRegs[dest] = result;
			expReg.push_back(dest);
			expData.push_back(result);
			expTest.push_back(testName);
		end
	endfunction

	////////////////////////////////////////////////////////////
	// four-phase instruction send, called at edge plus drive delay
	////////////////////////////////////////////////////////////
	task automatic sendInstr(cpuPkg::word_t ins);
		applyToModel(ins);
		sentCount++;
		instr    = ins;
		instrReq = 1'b1;
		// wait for ack, then release req
		do begin
			@(posedge clk);
			#DRIVE_DELAY;
		end while (!instrAck);
		instrReq = 1'b0;
		while (instrAck) begin
			@(posedge clk);
			#DRIVE_DELAY;
		end
	endtask

	// write-back monitor, sampled mid-cycle
	task automatic checkWriteback();
		string             name;
		cpuPkg::regAddr_t  expectReg;
		cpuPkg::word_t     data;
		if (expReg.size() == 0) begin
			otherErrors++;
			$display("unexpected write-back to r%0d with nothing left to retire", wbReg);
		end else begin
			name      = expTest.pop_front();
			expectReg = expReg.pop_front();
			data      = expData.pop_front();
			checkReg(name, expectReg, wbReg);
			checkWord(name, data, wbData);
		end
	endtask

	always @(negedge clk) begin
		if (!reset && wbValid)
			checkWriteback();
	end

	////////////////////////////////////////////////////////////
	// directed tests
	////////////////////////////////////////////////////////////
	task automatic testReset();
		testName = "reset";
		reset    = 1'b1;
		repeat (RESET_CYCLES) begin
			@(posedge clk);
			#DRIVE_DELAY;
			checkBit(testName, "instrAck in reset", 1'b0, instrAck);
			checkBit(testName, "wbValid in reset", 1'b0, wbValid);
		end
		reset = 1'b0;
		// idle port, nothing should move
		repeat (4) begin
			@(posedge clk);
			#DRIVE_DELAY;
			checkBit(testName, "instrAck idle", 1'b0, instrAck);
			checkBit(testName, "wbValid idle", 1'b0, wbValid);
		end
		sendInstr(rType(5'd0, 5'd0, 5'd1, cpuPkg::FUNCT_ADD));
		sendInstr(rType(5'd3, 5'd4, 5'd2, cpuPkg::FUNCT_OR));
	endtask

	task automatic testArith();
		testName = "arith";
		sendInstr(iType(cpuPkg::OPC_ADDI, 5'd0, 5'd1, 16'd100));
		// -7
		sendInstr(iType(cpuPkg::OPC_ADDI, 5'd0, 5'd2, 16'hfff9));
		sendInstr(iType(cpuPkg::OPC_ADDI, 5'd0, 5'd3, 16'h7fff));
		sendInstr(rType(5'd1, 5'd2, 5'd4, cpuPkg::FUNCT_ADD));
		sendInstr(rType(5'd2, 5'd1, 5'd5, cpuPkg::FUNCT_SUB));
		sendInstr(rType(5'd1, 5'd3, 5'd6, cpuPkg::FUNCT_AND));
		sendInstr(rType(5'd2, 5'd3, 5'd7, cpuPkg::FUNCT_OR));
		// signed compares with negative operands
		sendInstr(rType(5'd2, 5'd1, 5'd8, cpuPkg::FUNCT_SLT));
		sendInstr(rType(5'd1, 5'd2, 5'd9, cpuPkg::FUNCT_SLT));
		sendInstr(rType(5'd2, 5'd5, 5'd10, cpuPkg::FUNCT_SLT));
		sendInstr(rType(5'd5, 5'd2, 5'd11, cpuPkg::FUNCT_SLT));
	endtask

	task automatic testDeps();
		testName = "deps";
		sendInstr(iType(cpuPkg::OPC_ADDI, 5'd0, 5'd12, 16'd3));
		sendInstr(rType(5'd12, 5'd12, 5'd13, cpuPkg::FUNCT_ADD));
		sendInstr(rType(5'd13, 5'd12, 5'd14, cpuPkg::FUNCT_SUB));
		sendInstr(rType(5'd14, 5'd13, 5'd15, cpuPkg::FUNCT_OR));
		sendInstr(iType(cpuPkg::OPC_SW, 5'd0, 5'd15, 16'd8));
		// load-use pairs
		sendInstr(iType(cpuPkg::OPC_LW, 5'd0, 5'd16, 16'd8));
		sendInstr(rType(5'd16, 5'd16, 5'd17, cpuPkg::FUNCT_ADD));
		sendInstr(iType(cpuPkg::OPC_LW, 5'd0, 5'd18, 16'd8));
		sendInstr(iType(cpuPkg::OPC_ADDI, 5'd18, 5'd18, 16'd1));
	endtask

	task automatic testMemory();
		testName = "memory";
		sendInstr(iType(cpuPkg::OPC_ADDI, 5'd0, 5'd1, 16'h0055));
		sendInstr(iType(cpuPkg::OPC_ADDI, 5'd0, 5'd2, 16'hffff));
		sendInstr(iType(cpuPkg::OPC_SW, 5'd0, 5'd1, 16'd0));
		sendInstr(iType(cpuPkg::OPC_SW, 5'd0, 5'd2, 16'd4));
		sendInstr(iType(cpuPkg::OPC_LW, 5'd0, 5'd3, 16'd0));
		sendInstr(iType(cpuPkg::OPC_LW, 5'd0, 5'd4, 16'd4));
		// overwrite, then read back
		sendInstr(iType(cpuPkg::OPC_SW, 5'd0, 5'd2, 16'd0));
		sendInstr(iType(cpuPkg::OPC_LW, 5'd0, 5'd5, 16'd0));
		// untouched word
		sendInstr(iType(cpuPkg::OPC_LW, 5'd0, 5'd6, 16'd200));
	endtask

	task automatic testDiscard();
		testName = "discard";
		sendInstr(rType(5'd1, 5'd2, 5'd0, cpuPkg::FUNCT_ADD));
		sendInstr(iType(cpuPkg::OPC_ADDI, 5'd0, 5'd0, 16'd9));
		// offset and target bits land on nonzero rt and rd fields
		sendInstr(iType(cpuPkg::OPC_BEQ, 5'd1, 5'd2, 16'h1804));
		sendInstr({cpuPkg::OPC_J, 5'd1, 5'd3, 5'd4, 11'h010});
		sendInstr(iType(cpuPkg::OPC_LW, 5'd0, 5'd0, 16'd0));
		// later ones still retire in order
		sendInstr(iType(cpuPkg::OPC_ADDI, 5'd0, 5'd20, 16'd20));
		sendInstr(rType(5'd20, 5'd20, 5'd21, cpuPkg::FUNCT_ADD));
	endtask

	function automatic cpuPkg::funct_t pickFunct();
		case ($urandom_range(0, 4))
			0:       return cpuPkg::FUNCT_ADD;
			1:       return cpuPkg::FUNCT_SUB;
			2:       return cpuPkg::FUNCT_AND;
			3:       return cpuPkg::FUNCT_OR;
			default: return cpuPkg::FUNCT_SLT;
		endcase
	endfunction

	task automatic testRandom();
		cpuPkg::word_t     ins;
		cpuPkg::regAddr_t  rs;
		cpuPkg::regAddr_t  rt;
		cpuPkg::regAddr_t  rd;
		logic [15:0]       offset;
		testName = "random";
		for (int n = 0; n < RANDOM_COUNT; n++) begin
			repeat ($urandom_range(0, 3)) begin
				@(posedge clk);
				#DRIVE_DELAY;
			end
			rs     = cpuPkg::regAddr_t'($urandom_range(1, 7));
			rt     = cpuPkg::regAddr_t'($urandom_range(1, 7));
			rd     = cpuPkg::regAddr_t'($urandom_range(1, 7));
			// word-aligned, first 16 words
			offset = 16'(4 * $urandom_range(0, 15));
			case ($urandom_range(0, 3))
				0:       ins = iType(cpuPkg::OPC_ADDI, rs, rt, 16'($urandom_range(0, 65535)));
				1:       ins = rType(rs, rt, rd, pickFunct());
				2:       ins = iType(cpuPkg::OPC_LW, 5'd0, rt, offset);
				default: ins = iType(cpuPkg::OPC_SW, 5'd0, rt, offset);
			endcase
			sendInstr(ins);
		end
	endtask

	// let the pipe empty, then look for missing write-backs
	task automatic drainPipe();
		int waited;
		waited = 0;
		while (expReg.size() != 0 && waited < 20) begin
			@(posedge clk);
			waited++;
		end
		repeat (6) @(posedge clk);
		if (expReg.size() != 0) begin
			otherErrors++;
			$display("%0d expected write-backs never appeared", expReg.size());
		end
	endtask

	////////////////////////////////////////////////////////////
	// watchdog, budget grows with each instruction sent
	////////////////////////////////////////////////////////////
	initial begin : watchdog
		while (cycleCount <= CYCLES_PER_INSTR * sentCount + BASE_CYCLES) begin
			@(posedge clk);
			cycleCount++;
		end
		$display("timeout after %0d cycles with %0d instructions sent", cycleCount, sentCount);
		$display("value errors: %0d, other errors: %0d", valueErrors, otherErrors + 1);
		$display("STATUS: FAIL");
		$finish;
	end

	initial begin
		reset    = 1'b1;
		instrReq = 1'b0;
		instr    = '0;
		for (int i = 0; i < cpuPkg::REG_COUNT; i++)
			refRegs[i] = '0;
		for (int i = 0; i < cpuPkg::DMEM_WORDS; i++)
			refMem[i] = '0;
		seedValue = $urandom(RAND_SEED);
		testReset();
		testArith();
		testDeps();
		testMemory();
		testDiscard();
		testRandom();
		drainPipe();
		$display("value errors: %0d, other errors: %0d", valueErrors, otherErrors);
		if (valueErrors == 0 && otherErrors == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule
